// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module matmod_tb -f project.f -o Vmatmod_tb
	./obj_dir/Vmatmod_tb +verilator+error+limit+1000 | tee sim.log
	grep -q "^test passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

// File: project.f
verilog/matmod_pkg.sv
verilog/element_sequencer.sv
verilog/mod_product_stage.sv
verilog/result_writer.sv
verilog/matrix_elementwise_multiplier.sv
tests/matmod_assert.sv
tests/matmod_checker.sv
tests/matmod_tb.sv

// File: tests/matmod_assert.sv
// Concurrent checks on the output pulse relations, bound into the multiplier top level
`timescale 1ns/1ns
`default_nettype none

module matmod_assert (
  input wire CLK,
  input wire RST,
  input wire elem_strobe,
  input wire out_j_enable,
  input wire out_i_enable,
  input wire ready
);

  ////////////////////////////////////////
  // Pulse nesting
  ////////////////////////////////////////

  // End of matrix is always end of a row
  ready_in_row: assert property (@(posedge CLK) disable iff (RST) ready |-> out_i_enable)
    else $error("ready pulse without out_i_enable");

  // End of row always carries a result
  row_in_result: assert property (@(posedge CLK) disable iff (RST) out_i_enable |-> out_j_enable)
    else $error("out_i_enable pulse without out_j_enable");

  ////////////////////////////////////////
  // Latency
  ////////////////////////////////////////

  // Four register stages from strobe to result
  result_latency: assert property (@(posedge CLK) disable iff (RST)
    out_j_enable |-> $past(elem_strobe, 4))
    else $error("out_j_enable not 4 cycles after an elem_strobe");

endmodule

`default_nettype wire

// File: tests/matmod_cases.txt
# J size_i size_j modulo : open a job, all hex, modulo 0 is a start the DUT must ignore
# E a b result / B a b result : element after a random gap / with no gap, result = a*b mod m
# S a b : strobe outside any job, no result may come out
S 0005 0007
J 01 01 0007
E 000a 000b 0005
J 01 03 0001
E ffff ffff 0000
E 1234 5678 0000
E 0000 0001 0000
J 03 01 ffff
E ffff ffff 0000
E fffe fffe 0001
E 0002 8000 0001
J 02 03 0064
B 000c 000d 0038
B 0063 0063 0001
B 0100 0100 0024
B ffff 0002 0046
B 0007 0009 003f
B 0000 1234 0000
J 02 02 000d
B 0010 0010 0009
E 00ff 0002 0003
E 1000 0003 0003
E 0005 0005 000c
S 0003 0003
J 02 02 0000
S 0001 0002
S 0003 0004
J 01 02 fff1
E ffff ffff 00c4
E 8000 0002 000f

// File: tests/matmod_checker.sv
// Watches the multiplier outputs and compares each result pulse with the queued expected result
`timescale 1ns/1ns
`default_nettype none

module matmod_checker (
  input  wire                      CLK,
  input  wire                      RST,
  // Expected result, pushed with its strobe
  input  wire matmod_pkg::result_s expected,
  // DUT outputs
  input  wire matmod_pkg::word_t   data_out,
  input  wire                      out_i_enable,
  input  wire                      out_j_enable,
  input  wire                      ready,
  // End of stimulus
  input  wire                      done,
  output int                       errors,
  output int                       pending
);

  matmod_pkg::result_s exp_q[$];
  int unsigned         due_q[$];
  matmod_pkg::result_s head;
  int unsigned         head_due;
  int unsigned         cycle;
  logic                done_seen;

  always @(posedge CLK) begin
    if (RST) begin
      cycle     = 0;
      errors    = 0;
      done_seen = 1'b0;
      exp_q.delete();
      due_q.delete();
    end else begin
      cycle = cycle + 1;
      // Result is due 4 cycles after its strobe
      if (expected.valid) begin
        exp_q.push_back(expected);
        due_q.push_back(cycle + 4);
      end
      if ((out_i_enable || ready) && !out_j_enable) begin
        $display("Row or matrix end pulse at %0t came without a result pulse", $time);
        errors = errors + 1;
      end
      if (out_j_enable) begin
        if (exp_q.size() == 0) begin
          $display("Result pulse at %0t came when no result was expected", $time);
          errors = errors + 1;
        end else begin
          head     = exp_q.pop_front();
          head_due = due_q.pop_front();
          if (cycle != head_due) begin
            $display("Result pulse at %0t came at cycle %0d, due at cycle %0d",
                     $time, cycle, head_due);
            errors = errors + 1;
          end
          if (data_out != head.value) begin
            $display("Error at %0t: data_out = %h, expected %h", $time, data_out, head.value);
            errors = errors + 1;
          end
          if (out_i_enable != head.row_end) begin
            $display("Error at %0t: out_i_enable = %b, expected %b",
                     $time, out_i_enable, head.row_end);
            errors = errors + 1;
          end
          if (ready != head.last) begin
            $display("Error at %0t: ready = %b, expected %b", $time, ready, head.last);
            errors = errors + 1;
          end
        end
      end
      // Anything left over was lost in the pipeline
      if (done && !done_seen) begin
        done_seen = 1'b1;
        if (exp_q.size() != 0) begin
          $display("%0d expected results never came out", exp_q.size());
          errors = errors + 1;
        end
      end
      pending = exp_q.size();
    end
  end

endmodule

`default_nettype wire

// File: tests/matmod_tb.sv
// Testbench top that reads the case file and drives jobs and element strobes with random gaps
`timescale 1ns/1ns
`default_nettype none

module matmod_tb;

  // One line of the case file
  typedef struct packed {
    logic [7:0]        kind;
    matmod_pkg::word_t p0;
    matmod_pkg::word_t p1;
    matmod_pkg::word_t p2;
  } case_s;

  logic                CLK;
  logic                RST;
  logic                start;
  logic                elem_strobe;
  matmod_pkg::index_t  size_i;
  matmod_pkg::index_t  size_j;
  matmod_pkg::word_t   modulo;
  matmod_pkg::word_t   data_a;
  matmod_pkg::word_t   data_b;
  matmod_pkg::word_t   data_out;
  logic                out_i_enable;
  logic                out_j_enable;
  logic                ready;
  matmod_pkg::result_s expected;
  logic                done;
  int                  errors;
  int                  pending;

  case_s       cases[$];
  logic [31:0] lfsr;
  int          cycles;
  int          limit;
  int          total;
  logic        loaded;
  // Position inside the open job
  int          row;
  int          col;
  int          rows;
  int          cols;

  matrix_elementwise_multiplier dut_i (
    .CLK (CLK), .RST (RST), .start (start), .size_i (size_i), .size_j (size_j),
    .modulo (modulo), .elem_strobe (elem_strobe), .data_a (data_a), .data_b (data_b),
    .data_out (data_out), .out_i_enable (out_i_enable), .out_j_enable (out_j_enable),
    .ready (ready)
  );

  matmod_checker checker_i (
    .CLK (CLK), .RST (RST), .expected (expected), .data_out (data_out),
    .out_i_enable (out_i_enable), .out_j_enable (out_j_enable), .ready (ready),
    .done (done), .errors (errors), .pending (pending)
  );

  bind matrix_elementwise_multiplier matmod_assert assert_i (
    .CLK (CLK), .RST (RST), .elem_strobe (elem_strobe), .out_j_enable (out_j_enable),
    .out_i_enable (out_i_enable), .ready (ready)
  );

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  // Taps 32, 22, 2 and 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // Two bits with one step each
  function automatic int random_gap();
    int g;
    g = 0;
    repeat (2) begin
      lfsr = lfsr_step(lfsr);
      g    = (g << 1) | int'(lfsr[0]);
    end
    return g;
  endfunction

  task automatic load_cases(output logic ok);
    int    fd;
    int    n;
    int    v0;
    int    v1;
    int    v2;
    string line;
    string tag;
    case_s c;
    ok = 1'b0;
    fd = $fopen("tests/matmod_cases.txt", "r");
    if (fd != 0) begin
      ok = 1'b1;
      while ($fgets(line, fd) != 0) begin
        v2 = 0;
        n  = $sscanf(line, "%s %h %h %h", tag, v0, v1, v2);
        // Comment and blank lines are skipped
        if (n >= 3 && tag != "#") begin
          c.kind = tag.getc(0);
          c.p0   = matmod_pkg::word_t'(v0);
          c.p1   = matmod_pkg::word_t'(v1);
          c.p2   = matmod_pkg::word_t'(v2);
          cases.push_back(c);
          limit  = limit + 8;
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic quiet_cycles(input int n);
    repeat (n) begin
      @(posedge CLK);
      start          <= 1'b0;
      elem_strobe    <= 1'b0;
      expected.valid <= 1'b0;
    end
  endtask

  task automatic open_job(input case_s c);
    @(posedge CLK);
    start          <= 1'b1;
    elem_strobe    <= 1'b0;
    expected.valid <= 1'b0;
    size_i         <= matmod_pkg::index_t'(c.p0);
    size_j         <= matmod_pkg::index_t'(c.p1);
    modulo         <= c.p2;
    rows = int'(c.p0);
    cols = int'(c.p1);
    row  = 0;
    col  = 0;
  endtask

  // Strobe one element; tags follow row-major order of the open job
  task automatic send_element(input case_s c, input logic check);
    logic row_end;
    row_end = (col == cols - 1);
    @(posedge CLK);
    start            <= 1'b0;
    elem_strobe      <= 1'b1;
    data_a           <= c.p0;
    data_b           <= c.p1;
    expected.valid   <= check;
    expected.value   <= c.p2;
    expected.row_end <= row_end;
    expected.last    <= row_end && (row == rows - 1);
    if (check) begin
      col = row_end ? 0 : col + 1;
      row = row_end ? row + 1 : row;
    end
  endtask

  ////////////////////////////////////////
  // Clock and timeout
  ////////////////////////////////////////

  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;
  end

  always @(posedge CLK) begin
    cycles <= cycles + 1;
    if (cycles >= limit) begin
      $display("Timeout after %0d cycles with %0d results still pending", cycles, pending);
      $display("test failed");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  initial begin
    RST         = 1'b1;
    start       = 1'b0;
    elem_strobe = 1'b0;
    size_i      = '0;
    size_j      = '0;
    modulo      = '0;
    data_a      = '0;
    data_b      = '0;
    expected    = '0;
    done        = 1'b0;
    lfsr        = 32'he360;
    cycles      = 0;
    // Margin for reset and drain
    limit       = 100;
    load_cases(loaded);
    repeat (16) @(posedge CLK);
    RST <= 1'b0;
    if (loaded) begin
      foreach (cases[k]) begin
        case (cases[k].kind)
          "J": open_job(cases[k]);
          "B": send_element(cases[k], 1'b1);
          "E": begin
            quiet_cycles(random_gap());
            send_element(cases[k], 1'b1);
          end
          default: begin
            quiet_cycles(random_gap());
            send_element(cases[k], 1'b0);
          end
        endcase
      end
      quiet_cycles(1);
      // Queue is settled away from the clock edge
      @(negedge CLK);
      while (pending != 0) begin
        @(negedge CLK);
      end
      // Room for any stray pulse
      quiet_cycles(6);
    end else begin
      $display("Case file tests/matmod_cases.txt could not be read");
    end
    done <= 1'b1;
    repeat (2) @(negedge CLK);
    total = loaded ? errors : errors + 1;
    $display("Run finished with %0d errors", total);
    if (total == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/element_sequencer.sv
// Pipeline stage 1: takes a job start, counts rows and columns, tags each element strobe
`timescale 1ns/1ns
`default_nettype none

module element_sequencer (
  input  wire                     CLK,
  input  wire                     RST,
  // Job control
  input  wire                     start,
  input  wire matmod_pkg::index_t size_i,
  input  wire matmod_pkg::index_t size_j,
  input  wire matmod_pkg::word_t  modulo,
  // Element input
  input  wire                     elem_strobe,
  input  wire matmod_pkg::word_t  data_a,
  input  wire matmod_pkg::word_t  data_b,
  // Tagged element out
  output matmod_pkg::elem_s       elem
);

  ////////////////////////////////////////
  // Signals
  ////////////////////////////////////////

  matmod_pkg::seq_state_e state;

  // Job settings, held for the whole job
  matmod_pkg::index_t last_row;
  matmod_pkg::index_t last_col;
  matmod_pkg::word_t  job_modulo;

  // Position of the next element
  matmod_pkg::index_t row;
  matmod_pkg::index_t col;

  logic start_ok;
  logic take;
  logic col_end;
  logic row_last;

  ////////////////////////////////////////
  // Control
  ////////////////////////////////////////

  // Zero modulo, empty matrix or a colliding strobe means no job
  assign start_ok = start && (modulo != '0) && (size_i != '0) && (size_j != '0)
                    && !elem_strobe;

  // Strobes only count while a job is open
  assign take     = (state == matmod_pkg::seq_run) && elem_strobe;
  assign col_end  = (col == last_col);
  assign row_last = (row == last_row);

  // FSM, job latch and counters
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state      <= matmod_pkg::seq_idle;
      last_row   <= '0;
      last_col   <= '0;
      job_modulo <= '0;
      row        <= '0;
      col        <= '0;
    end else begin
      case (state)
        matmod_pkg::seq_idle: begin
          if (start_ok) begin
            // Keep sizes as last index
            last_row   <= size_i - 1'b1;
            last_col   <= size_j - 1'b1;
            job_modulo <= modulo;
            row        <= '0;
            col        <= '0;
            state      <= matmod_pkg::seq_run;
          end
        end
        matmod_pkg::seq_run: begin
          if (elem_strobe) begin
            if (col_end) begin
              col <= '0;
              // Last element closes the job
              if (row_last) begin
                state <= matmod_pkg::seq_idle;
              end else begin
                row <= row + 1'b1;
              end
            end else begin
              col <= col + 1'b1;
            end
          end
        end
        default: begin
          state <= matmod_pkg::seq_idle;
        end
      endcase
    end
  end

  ////////////////////////////////////////
  // Element register
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      elem <= '0;
    end else begin
      // One-cycle strobe
      elem.valid <= take;
      if (take) begin
        elem.a       <= data_a;
        elem.b       <= data_b;
        // Modulo rides with the element
        elem.modulo  <= job_modulo;
        elem.row_end <= col_end;
        elem.last    <= col_end && row_last;
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/matmod_pkg.sv
// Widths, vector types and stage structs shared by the multiplier pipeline and its testbench
`default_nettype none

package matmod_pkg;

  ////////////////////////////////////////
  // Widths
  ////////////////////////////////////////

  // Operand, modulo and result
  localparam int word_w = 16;
  // Full product of two operands
  localparam int prod_w = 2 * word_w;
  // Row and column counters, 255 per side at most
  localparam int index_w = 8;

  ////////////////////////////////////////
  // Vector types
  ////////////////////////////////////////

  typedef logic [word_w-1:0]  word_t;
  typedef logic [prod_w-1:0]  product_t;
  typedef logic [index_w-1:0] index_t;

  // Sequencer FSM
  typedef enum logic {
    seq_idle,
    seq_run
  } seq_state_e;

  ////////////////////////////////////////
  // Stage structs
  ////////////////////////////////////////

  // Tagged element, sequencer to product register
  typedef struct packed {
    logic  valid;
    word_t a;
    word_t b;
    word_t modulo;
    logic  row_end;
    logic  last;
  } elem_s;

  // Product register contents
  typedef struct packed {
    logic     valid;
    product_t product;
    word_t    modulo;
    logic     row_end;
    logic     last;
  } prod_s;

  // Reduced result, product stage to writer
  typedef struct packed {
    logic  valid;
    word_t value;
    logic  row_end;
    logic  last;
  } result_s;

endpackage

`default_nettype wire

// File: verilog/matrix_elementwise_multiplier.sv
// Top level of the streaming modular element-wise matrix multiplier, four-cycle pipeline
`timescale 1ns/1ns
`default_nettype none

module matrix_elementwise_multiplier (
  input  wire                     CLK,
  input  wire                     RST,
  // Job control
  input  wire                     start,
  input  wire matmod_pkg::index_t size_i,
  input  wire matmod_pkg::index_t size_j,
  input  wire matmod_pkg::word_t  modulo,
  // Elements in
  input  wire                     elem_strobe,
  input  wire matmod_pkg::word_t  data_a,
  input  wire matmod_pkg::word_t  data_b,
  // Results out
  output matmod_pkg::word_t       data_out,
  output logic                    out_i_enable,
  output logic                    out_j_enable,
  output logic                    ready
);

  // Stage links
  matmod_pkg::elem_s   elem;
  matmod_pkg::result_s result;

  ////////////////////////////////////////
  // Stage 1, sequencing and tags
  ////////////////////////////////////////

  element_sequencer seq_i (
    .CLK         (CLK),
    .RST         (RST),
    .start       (start),
    .size_i      (size_i),
    .size_j      (size_j),
    .modulo      (modulo),
    .elem_strobe (elem_strobe),
    .data_a      (data_a),
    .data_b      (data_b),
    .elem        (elem)
  );

  // Stages 2 and 3, product and reduction
  mod_product_stage prod_i (
    .CLK    (CLK),
    .RST    (RST),
    .elem   (elem),
    .result (result)
  );

  // Stage 4, outputs
  result_writer writer_i (
    .CLK          (CLK),
    .RST          (RST),
    .result       (result),
    .data_out     (data_out),
    .out_i_enable (out_i_enable),
    .out_j_enable (out_j_enable),
    .ready        (ready)
  );

endmodule

`default_nettype wire

// File: verilog/mod_product_stage.sv
// Pipeline stages 2 and 3: registered full product, then registered reduction modulo m
`timescale 1ns/1ns
`default_nettype none

module mod_product_stage (
  input  wire                      CLK,
  input  wire                      RST,
  // From the sequencer
  input  wire matmod_pkg::elem_s   elem,
  // To the writer
  output matmod_pkg::result_s      result
);

  ////////////////////////////////////////
  // Signals
  ////////////////////////////////////////

  // Product register
  matmod_pkg::prod_s prod;

  // Reduction of the held product
  matmod_pkg::product_t remainder;

  ////////////////////////////////////////
  // Stage 2, product
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      prod <= '0;
    end else begin
      prod.valid <= elem.valid;
      if (elem.valid) begin
        // Full width, no overflow
        prod.product <= matmod_pkg::product_t'(elem.a) * matmod_pkg::product_t'(elem.b);
        prod.modulo  <= elem.modulo;
        prod.row_end <= elem.row_end;
        prod.last    <= elem.last;
      end
    end
  end

  ////////////////////////////////////////
  // Stage 3, reduction
  ////////////////////////////////////////

  // Each product uses its own job modulo
  assign remainder = prod.product % matmod_pkg::product_t'(prod.modulo);

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      result <= '0;
    end else begin
      result.valid <= prod.valid;
      if (prod.valid) begin
        // Remainder is below modulo, fits a word
        result.value   <= matmod_pkg::word_t'(remainder);
        result.row_end <= prod.row_end;
        result.last    <= prod.last;
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/result_writer.sv
// Pipeline stage 4: registers the result word and turns the tags into output pulses
`timescale 1ns/1ns
`default_nettype none

module result_writer (
  input  wire                       CLK,
  input  wire                       RST,
  // From the product stage
  input  wire matmod_pkg::result_s  result,
  // Outside outputs
  output matmod_pkg::word_t         data_out,
  output logic                      out_i_enable,
  output logic                      out_j_enable,
  output logic                      ready
);

  ////////////////////////////////////////
  // Data
  ////////////////////////////////////////

  // Held between pulses
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      data_out <= '0;
    end else if (result.valid) begin
      data_out <= result.value;
    end
  end

  ////////////////////////////////////////
  // Pulses
  ////////////////////////////////////////

  // All three are one-cycle strobes
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      out_j_enable <= 1'b0;
      out_i_enable <= 1'b0;
      ready        <= 1'b0;
    end else begin
      // Every element
      out_j_enable <= result.valid;
      // End of a row
      out_i_enable <= result.valid && result.row_end;
      // End of the matrix
      ready        <= result.valid && result.last;
    end
  end

endmodule

`default_nettype wire
